//--- Bender.yml
package:
  name: spi_bridge

sources:
  - files:
      - logic/spi_bridge_pkg.sv
      - logic/spi_frame_rx.sv
      - logic/spi_reg_bank.sv
      - logic/spi_route.sv
      - logic/led_blinker.sv
      - logic/spi_bridge_top.sv
  - target: test
    files:
      - verif/spi_bridge_assertions.sv
      - verif/spi_bridge_tb.sv

//--- list.f
logic/spi_bridge_pkg.sv
logic/spi_frame_rx.sv
logic/spi_reg_bank.sv
logic/spi_route.sv
logic/led_blinker.sv
logic/spi_bridge_top.sv
verif/spi_bridge_assertions.sv
verif/spi_bridge_tb.sv

//--- logic/led_blinker.sv
module led_blinker #(
  parameter int div_bits = spi_bridge_pkg::blink_div_bits
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  spi_bridge_pkg::led_ctrl_t led_ctrl,
  output logic [1:0]                led
);

  // free running divider with the led bits on top
  logic [div_bits+1:0] cnt_q;
  logic [1:0] top;
  logic [1:0] gray;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_q + 1'b1;
  end

  // 00 01 11 10 so one led changes per step
  assign top  = cnt_q[div_bits+1:div_bits];
  assign gray = top ^ (top >> 1);

  // manual override from the led register
  assign led = led_ctrl.manual ? led_ctrl.leds : gray;

endmodule

//--- logic/spi_bridge_pkg.sv
package spi_bridge_pkg;

  //////////////////////////////
  // sizes and addresses
  //////////////////////////////

  // routed peripherals in bit order adc 0 / dac 1 / flash 2
  localparam int n_periph = 3;

  // register frame is address byte then value byte
  localparam int frame_bits = 16;

  // bit counter must reach frame_bits itself
  localparam int cnt_bits = $clog2(frame_bits + 1);

  // blinker counter bits below the two led bits
  localparam int blink_div_bits = 20;

  //////////////////////////////
  // vector types
  //////////////////////////////

  typedef logic [7:0]          reg_byte_t;
  typedef logic [n_periph-1:0] periph_vec_t;
  typedef logic [cnt_bits-1:0] bit_cnt_t;

  // register addresses
  localparam reg_byte_t addr_led = 8'd7;
  localparam reg_byte_t addr_mux = 8'd8;
  localparam reg_byte_t addr_dac = 8'd9;

  //////////////////////////////
  // bundles
  //////////////////////////////

  // master side pins of the shared bus
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
    logic special_n;
  } spi_pins_t;

  // bus at rest with no select asserted
  localparam spi_pins_t pins_idle = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0, special_n: 1'b1};

  // addr lands in the high byte
  typedef struct packed {
    reg_byte_t addr;
    reg_byte_t value;
  } spi_frame_t;

  // ldac sits in bit 0
  typedef struct packed {
    logic uni_bip_b;
    logic uni_bip_a;
    logic rst;
    logic ldac;
  } dac_ctrl_t;

  typedef struct packed {
    logic       manual;
    logic [1:0] leds;
  } led_ctrl_t;

  // frame receiver states
  typedef enum logic [1:0] {
    rx_idle,
    rx_shift,
    rx_overrun
  } rx_state_e;

endpackage

//--- logic/spi_bridge_top.sv
module spi_bridge_top #(
  parameter int div_bits = spi_bridge_pkg::blink_div_bits
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  spi_bridge_pkg::spi_pins_t   master,
  output logic                        miso,
  output spi_bridge_pkg::periph_vec_t periph_cs_n,
  output spi_bridge_pkg::periph_vec_t periph_sclk,
  output spi_bridge_pkg::periph_vec_t periph_mosi,
  input  spi_bridge_pkg::periph_vec_t periph_miso,
  output spi_bridge_pkg::dac_ctrl_t   dac_ctrl,
  output logic [1:0]                  led
);

  spi_bridge_pkg::spi_frame_t  frame;
  logic                        frame_valid;
  spi_bridge_pkg::periph_vec_t mux_sel;
  spi_bridge_pkg::led_ctrl_t   led_ctrl;

  //////////////////////////////
  // register path
  //////////////////////////////

  // register frames from the shared bus
  spi_frame_rx frame_rx_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pins        (master),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  spi_reg_bank reg_bank_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .mux_sel     (mux_sel),
    .led_ctrl    (led_ctrl),
    .dac_ctrl    (dac_ctrl)
  );

  //////////////////////////////
  // pass through and leds
  //////////////////////////////

  // no clock in this path
  spi_route route_i (
    .pins        (master),
    .mux_sel     (mux_sel),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .miso        (miso)
  );

  led_blinker #(
    .div_bits (div_bits)
  ) blinker_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .led_ctrl (led_ctrl),
    .led      (led)
  );

endmodule

//--- logic/spi_frame_rx.sv
module spi_frame_rx (
  input  logic                       clk,
  input  logic                       rst_n,
  input  spi_bridge_pkg::spi_pins_t  pins,
  output spi_bridge_pkg::spi_frame_t frame,
  output logic                       frame_valid
);

  spi_bridge_pkg::spi_pins_t sync_q1;
  spi_bridge_pkg::spi_pins_t sync_q2;
  spi_bridge_pkg::spi_pins_t prev_q;
  spi_bridge_pkg::rx_state_e state_q;
  spi_bridge_pkg::bit_cnt_t  cnt_q;
  logic [spi_bridge_pkg::frame_bits-1:0] shift_q;
  logic sclk_fall;
  logic cs_fall;
  logic cs_rise;
  logic full;

  //////////////////////////////
  // pin synchronizer
  //////////////////////////////

  // two flops then one more for edge detect
  // all four pins move together so mosi lines up with sclk
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sync_q1 <= spi_bridge_pkg::pins_idle;
      sync_q2 <= spi_bridge_pkg::pins_idle;
      prev_q  <= spi_bridge_pkg::pins_idle;
    end
    else
    begin
      sync_q1 <= pins;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
    end
  end

  // edges as seen after the synchronizer
  assign sclk_fall = prev_q.sclk & ~sync_q2.sclk;
  assign cs_fall   = prev_q.cs_n & ~sync_q2.cs_n;
  assign cs_rise   = ~prev_q.cs_n & sync_q2.cs_n;

  // exactly one frame worth of bits so far
  assign full = (cnt_q == spi_bridge_pkg::bit_cnt_t'(spi_bridge_pkg::frame_bits));

  //////////////////////////////
  // frame fsm
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q     <= spi_bridge_pkg::rx_idle;
      cnt_q       <= '0;
      frame_valid <= 1'b0;
    end
    else
    begin
      // strobe lasts one cycle
      frame_valid <= 1'b0;
      case (state_q)
        spi_bridge_pkg::rx_idle:
        begin
          // only register frames are taken in
          if (cs_fall && !sync_q2.special_n)
          begin
            state_q <= spi_bridge_pkg::rx_shift;
            cnt_q   <= '0;
          end
        end
        spi_bridge_pkg::rx_shift:
        begin
          if (cs_rise)
          begin
            // short frames are dropped here
            frame_valid <= full;
            state_q     <= spi_bridge_pkg::rx_idle;
          end
          else if (sclk_fall)
          begin
            // a 17th bit spoils the frame
            if (full)
              state_q <= spi_bridge_pkg::rx_overrun;
            else
              cnt_q <= cnt_q + 1'b1;
          end
        end
        spi_bridge_pkg::rx_overrun:
        begin
          // wait out the long frame
          if (cs_rise)
            state_q <= spi_bridge_pkg::rx_idle;
        end
        default:
          state_q <= spi_bridge_pkg::rx_idle;
      endcase
    end
  end

  // msb first shift on falling sclk
  always_ff @(posedge clk)
  begin
    if (state_q == spi_bridge_pkg::rx_shift && sclk_fall)
      shift_q <= {shift_q[spi_bridge_pkg::frame_bits-2:0], sync_q2.mosi};
  end

  // high byte addr and low byte value
  assign frame = spi_bridge_pkg::spi_frame_t'(shift_q);

endmodule

//--- logic/spi_reg_bank.sv
module spi_reg_bank (
  input  logic                        clk,
  input  logic                        rst_n,
  input  spi_bridge_pkg::spi_frame_t  frame,
  input  logic                        frame_valid,
  output spi_bridge_pkg::periph_vec_t mux_sel,
  output spi_bridge_pkg::led_ctrl_t   led_ctrl,
  output spi_bridge_pkg::dac_ctrl_t   dac_ctrl
);

  //////////////////////////////
  // register decode
  //////////////////////////////

  // one write per committed frame
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      // nothing routed and blinker mode
      mux_sel  <= '0;
      led_ctrl <= '0;
      dac_ctrl <= '0;
    end
    else if (frame_valid)
    begin
      case (frame.addr)
        spi_bridge_pkg::addr_mux:
        begin
          // one bit per peripheral
          mux_sel <= frame.value[spi_bridge_pkg::n_periph-1:0];
        end
        spi_bridge_pkg::addr_led:
        begin
          // bit 7 picks manual leds
          led_ctrl.manual <= frame.value[7];
          led_ctrl.leds   <= frame.value[1:0];
        end
        spi_bridge_pkg::addr_dac:
        begin
          // low nibble straight onto the dac pins
          dac_ctrl <= spi_bridge_pkg::dac_ctrl_t'(frame.value[3:0]);
        end
        default:
        begin
          // unknown address is ignored
          mux_sel <= mux_sel;
        end
      endcase
    end
  end

endmodule

//--- logic/spi_route.sv
module spi_route (
  input  spi_bridge_pkg::spi_pins_t   pins,
  input  spi_bridge_pkg::periph_vec_t mux_sel,
  input  spi_bridge_pkg::periph_vec_t periph_miso,
  output spi_bridge_pkg::periph_vec_t periph_cs_n,
  output spi_bridge_pkg::periph_vec_t periph_sclk,
  output spi_bridge_pkg::periph_vec_t periph_mosi,
  output logic                        miso
);

  // peripherals that see normal frames
  spi_bridge_pkg::periph_vec_t active;
  // lowest selected peripheral only
  spi_bridge_pkg::periph_vec_t first_sel;

  //////////////////////////////
  // chip select fan out
  //////////////////////////////

  // register frames keep every peripheral off the bus
  assign active = pins.special_n ? mux_sel : '0;

  always_comb
  begin
    for (int i = 0; i < spi_bridge_pkg::n_periph; i++)
    begin
      // selected follows the master and the rest idle
      periph_cs_n[i] = active[i] ? pins.cs_n : 1'b1;
      periph_sclk[i] = active[i] & pins.sclk;
      periph_mosi[i] = active[i] & pins.mosi;
    end
  end

  //////////////////////////////
  // miso select
  //////////////////////////////

  // isolate lowest set bit
  assign first_sel = active & (~active + 1'b1);

  // zero when nothing selected or during register frames
  assign miso = |(first_sel & periph_miso);

endmodule

//--- verif/spi_bridge_assertions.sv
// route and bank outputs meet in the top level next to clk
module spi_bridge_assertions (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        special_n,
  input spi_bridge_pkg::periph_vec_t mux_sel,
  input spi_bridge_pkg::periph_vec_t periph_cs_n,
  input spi_bridge_pkg::led_ctrl_t   led_ctrl,
  input spi_bridge_pkg::dac_ctrl_t   dac_ctrl
);

  // read by the testbench at the end of the run
  int fail_cnt = 0;

  //////////////////////////////
  // chip select rules
  //////////////////////////////

  // register frames keep every peripheral deselected
  cs_high_in_reg_frame: assert property (@(posedge clk) disable iff (!rst_n)
    !special_n |-> &periph_cs_n)
  else
  begin
    $error("chip select low during register frame");
    fail_cnt++;
  end

  // a peripheral outside the mux never sees a select
  cs_high_unselected: assert property (@(posedge clk) disable iff (!rst_n)
    &(periph_cs_n | mux_sel))
  else
  begin
    $error("unselected chip select driven low");
    fail_cnt++;
  end

  // register bank comes out of reset cleared
  regs_zero_after_reset: assert property (@(posedge clk)
    !rst_n |=> (mux_sel == '0 && led_ctrl == '0 && dac_ctrl == '0))
  else
  begin
    $error("register outputs not zero after reset");
    fail_cnt++;
  end

endmodule

bind spi_bridge_top spi_bridge_assertions assert_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .special_n   (master.special_n),
  .mux_sel     (mux_sel),
  .periph_cs_n (periph_cs_n),
  .led_ctrl    (led_ctrl),
  .dac_ctrl    (dac_ctrl)
);

//--- verif/spi_bridge_tb.sv
module spi_bridge_tb;

  // frames sent over the whole run
  localparam int n_frames    = 25;
  // sclk period in time units, 8 clk cycles of 4
  localparam int sclk_period = 32;
  localparam int watchdog_time = n_frames * spi_bridge_pkg::frame_bits * sclk_period * 2;

  logic                        clk;
  logic                        rst_n;
  spi_bridge_pkg::spi_pins_t   master;
  logic                        miso;
  spi_bridge_pkg::periph_vec_t periph_cs_n;
  spi_bridge_pkg::periph_vec_t periph_sclk;
  spi_bridge_pkg::periph_vec_t periph_mosi;
  spi_bridge_pkg::periph_vec_t periph_miso;
  spi_bridge_pkg::dac_ctrl_t   dac_ctrl;
  logic [1:0]                  led;

  int          err_cnt;
  logic [31:0] lfsr_q;

  // expected register contents
  spi_bridge_pkg::periph_vec_t exp_mux;
  spi_bridge_pkg::dac_ctrl_t   exp_dac;
  spi_bridge_pkg::led_ctrl_t   exp_led;

  spi_bridge_top #(
    .div_bits (2)
  ) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .master      (master),
    .miso        (miso),
    .periph_cs_n (periph_cs_n),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .periph_miso (periph_miso),
    .dac_ctrl    (dac_ctrl),
    .led         (led)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // blink order 00 01 11 10
  function automatic logic [1:0] next_gray(input logic [1:0] g);
    case (g)
      2'b00:   return 2'b01;
      2'b01:   return 2'b11;
      2'b11:   return 2'b10;
      default: return 2'b00;
    endcase
  endfunction

  // first selected peripheral wins
  function automatic logic lowest_miso(input spi_bridge_pkg::periph_vec_t sel,
                                       input spi_bridge_pkg::periph_vec_t m);
    logic r;
    logic found;
    int   i;
    r     = 1'b0;
    found = 1'b0;
    for (i = 0; i < spi_bridge_pkg::n_periph; i++)
    begin
      if (sel[i] && !found)
      begin
        r     = m[i];
        found = 1'b1;
      end
    end
    return r;
  endfunction

  task automatic check_vec(input string name, input spi_bridge_pkg::periph_vec_t exp,
                           input spi_bridge_pkg::periph_vec_t act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_dac(input string name, input spi_bridge_pkg::dac_ctrl_t exp,
                           input spi_bridge_pkg::dac_ctrl_t act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_led(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  //////////////////////////////
  // spi master
  //////////////////////////////

  // msb first, mosi set with rising sclk, sampled on falling
  task automatic spi_xfer(input logic special_n, input logic [31:0] data, input int nbits);
    int i;
    @(posedge clk);
    master.special_n <= special_n;
    master.cs_n      <= 1'b0;
    repeat (4) @(posedge clk);
    for (i = nbits - 1; i >= 0; i--)
    begin
      master.mosi <= data[i];
      master.sclk <= 1'b1;
      repeat (4) @(posedge clk);
      master.sclk <= 1'b0;
      repeat (4) @(posedge clk);
    end
    master.cs_n <= 1'b1;
    master.mosi <= 1'b0;
    repeat (4) @(posedge clk);
    master.special_n <= 1'b1;
  endtask

  // register frame then update the expected bank
  task automatic reg_write(input spi_bridge_pkg::reg_byte_t addr,
                           input spi_bridge_pkg::reg_byte_t value);
    spi_xfer(1'b0, {16'h0, addr, value}, spi_bridge_pkg::frame_bits);
    repeat (8) @(posedge clk);
    case (addr)
      spi_bridge_pkg::addr_mux:
        exp_mux = value[spi_bridge_pkg::n_periph-1:0];
      spi_bridge_pkg::addr_led:
      begin
        exp_led.manual = value[7];
        exp_led.leds   = value[1:0];
      end
      spi_bridge_pkg::addr_dac:
      begin
        exp_dac.ldac      = value[0];
        exp_dac.rst       = value[1];
        exp_dac.uni_bip_a = value[2];
        exp_dac.uni_bip_b = value[3];
      end
      default:
        exp_mux = exp_mux;
    endcase
  endtask

  task automatic check_regs();
    @(negedge clk);
    check_vec("mux_sel", exp_mux, dut_i.mux_sel);
    check_dac("dac_ctrl", exp_dac, dac_ctrl);
  endtask

  // gray stepping every 4 cycles from the next change on
  task automatic check_gray_steps();
    logic [1:0] prev;
    logic [1:0] cur;
    int         wait_n;
    int         step;
    int         c;
    @(negedge clk);
    prev   = led;
    wait_n = 0;
    while (led === prev && wait_n < 8)
    begin
      @(negedge clk);
      wait_n++;
    end
    if (led === prev)
    begin
      $display("LEDs did not change within 8 cycles at %0t", $time);
      err_cnt++;
    end
    else
    begin
      cur = next_gray(prev);
      for (step = 0; step < 6; step++)
      begin
        for (c = 0; c < 4; c++)
        begin
          check_led("led", cur, led);
          @(negedge clk);
        end
        cur = next_gray(cur);
      end
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_reset_state();
    @(negedge clk);
    check_vec("periph_cs_n", '1, periph_cs_n);
    check_dac("dac_ctrl", '0, dac_ctrl);
    // counter cleared so the first led state is 00
    check_led("led", 2'b00, led);
    check_gray_steps();
  endtask

  task automatic test_reg_writes();
    reg_write(spi_bridge_pkg::addr_dac, rand_bits(8));
    check_regs();
    reg_write(spi_bridge_pkg::addr_mux, rand_bits(8));
    check_regs();
    // unknown addresses leave the bank alone
    reg_write(8'h06, rand_bits(8));
    check_regs();
    reg_write(8'h8a, rand_bits(8));
    check_regs();
  endtask

  task automatic test_bad_length();
    spi_bridge_pkg::reg_byte_t v;
    // value that differs from the current dac bits
    v = {4'h0, ~exp_dac};
    // short frame would land as a dac write if the count were ignored
    spi_xfer(1'b0, {17'h0, spi_bridge_pkg::addr_dac[6:0], v}, 15);
    repeat (8) @(posedge clk);
    check_regs();
    // last 16 bits form a dac write if the overrun were missed
    spi_xfer(1'b0, {15'h0, 1'b1, spi_bridge_pkg::addr_dac, v}, 17);
    repeat (8) @(posedge clk);
    check_regs();
    // receiver takes a good frame again
    reg_write(spi_bridge_pkg::addr_dac, rand_bits(8));
    check_regs();
  endtask

  // normal frame of 8 bits with pass through checks
  task automatic route_frame(input spi_bridge_pkg::periph_vec_t sel);
    int i;
    int h;
    @(posedge clk);
    master.special_n <= 1'b1;
    master.cs_n      <= 1'b0;
    periph_miso      <= spi_bridge_pkg::periph_vec_t'(rand_bits(spi_bridge_pkg::n_periph));
    @(negedge clk);
    check_vec("periph_cs_n", ~sel, periph_cs_n);
    for (i = 0; i < 8; i++)
    begin
      for (h = 0; h < 2; h++)
      begin
        @(posedge clk);
        master.sclk <= (h == 0);
        if (h == 0)
          master.mosi <= rand_bits(1);
        periph_miso <= spi_bridge_pkg::periph_vec_t'(rand_bits(spi_bridge_pkg::n_periph));
        @(negedge clk);
        check_vec("periph_cs_n", ~sel, periph_cs_n);
        check_vec("periph_sclk", sel & {spi_bridge_pkg::n_periph{master.sclk}}, periph_sclk);
        check_vec("periph_mosi", sel & {spi_bridge_pkg::n_periph{master.mosi}}, periph_mosi);
        check_bit("miso", lowest_miso(sel, periph_miso), miso);
        repeat (3) @(posedge clk);
      end
    end
    master.cs_n <= 1'b1;
    master.mosi <= 1'b0;
    @(negedge clk);
    check_vec("periph_cs_n", '1, periph_cs_n);
  endtask

  task automatic test_routing();
    spi_bridge_pkg::periph_vec_t sels [8];
    int k;
    // one hot first then the multi bit values
    sels = '{3'b001, 3'b010, 3'b100, 3'b011, 3'b101, 3'b110, 3'b111, 3'b000};
    for (k = 0; k < 8; k++)
    begin
      reg_write(spi_bridge_pkg::addr_mux, {5'h0, sels[k]});
      check_regs();
      route_frame(sels[k]);
    end
  endtask

  task automatic test_led_override();
    logic [1:0] pick;
    int         c;
    pick = rand_bits(2);
    reg_write(spi_bridge_pkg::addr_led, {1'b1, 5'h0, pick});
    // held across several blink steps
    for (c = 0; c < 12; c++)
    begin
      @(negedge clk);
      check_led("led", exp_led.leds, led);
    end
    reg_write(spi_bridge_pkg::addr_led, 8'h00);
    check_gray_steps();
  endtask

  //////////////////////////////
  // run
  //////////////////////////////

  initial
  begin
    #(watchdog_time);
    $display("watchdog expired at %0t with tests still running", $time);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    err_cnt     = 0;
    lfsr_q      = 32'h39;
    rst_n       = 1'b0;
    master      = spi_bridge_pkg::pins_idle;
    periph_miso = '0;
    exp_mux     = '0;
    exp_dac     = '0;
    exp_led     = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_reg_writes();
    test_bad_length();
    test_routing();
    test_led_override();
    $display("check errors: %0d  assertion failures: %0d", err_cnt, dut_i.assert_i.fail_cnt);
    if (err_cnt == 0 && dut_i.assert_i.fail_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
